//--- translator_pkg.sv
// slave translator shared definitions
package translator_pkg;

   // ------------------------------
   // widths
   // ------------------------------

   // master side is byte addressed
   localparam int UAV_ADDRESS_W = 32;

   // same data width on both sides
   localparam int DATA_W = 32;

   localparam int BYTEENABLE_W = 4;   // byte lanes per word

   // low address bits that select a byte inside a word
   localparam int WORD_SHIFT = $clog2(BYTEENABLE_W);

   // slave side is word addressed
   localparam int AV_ADDRESS_W = UAV_ADDRESS_W - WORD_SHIFT;

   // ------------------------------
   // types
   // ------------------------------

   // master byte address
   typedef logic [UAV_ADDRESS_W-1:0] uav_addr_t;

   // slave word address
   typedef logic [AV_ADDRESS_W-1:0] av_addr_t;

   // one data word, read or write
   typedef logic [DATA_W-1:0] data_t;

   // one bit per byte lane
   typedef logic [BYTEENABLE_W-1:0] byteen_t;

endpackage

//--- request_stage.sv
// translator request stage
module request_stage
   import translator_pkg::*;
#(
   parameter int SETUP_CYCLES      = 1,
   parameter int READ_WAIT_CYCLES  = 2,
   parameter int WRITE_WAIT_CYCLES = 1,
   parameter int HOLD_CYCLES       = 1
) (
   input  logic      clk,
   input  logic      reset,

   // master side
   input  uav_addr_t uav_address,
   input  data_t     uav_writedata,
   input  byteen_t   uav_byteenable,
   input  logic      uav_read,
   input  logic      uav_write,
   output logic      uav_waitrequest,
   output logic      read_accept,         // to the read-latency pipe

   // slave side
   output av_addr_t  av_address,
   output data_t     av_writedata,
   output byteen_t   av_byteenable,
   output byteen_t   av_writebyteenable,
   output logic      av_read,
   output logic      av_write,
   output logic      av_begintransfer,
   output logic      av_chipselect
);

   // counter values that end each phase
   localparam int READ_DONE  = SETUP_CYCLES + READ_WAIT_CYCLES;
   localparam int WRITE_LAST = SETUP_CYCLES + WRITE_WAIT_CYCLES;  // last cycle of av_write
   localparam int WRITE_DONE = WRITE_LAST + HOLD_CYCLES;
   localparam int CNT_MAX    = (READ_DONE > WRITE_DONE) ? READ_DONE : WRITE_DONE;
   localparam int CNT_W      = (CNT_MAX > 0) ? $clog2(CNT_MAX + 1) : 1;

   logic [CNT_W-1:0] wait_cnt;
   logic             reset_override;    // first cycle out of reset
   logic             end_begintransfer; // begintransfer already given
   logic             transfer;
   logic             wait_read;
   logic             wait_write;

   assign transfer = uav_read | uav_write;

   // ------------------------------
   // address and data mapping
   // ------------------------------

   // byte address to word address
   assign av_address    = uav_address[UAV_ADDRESS_W-1:WORD_SHIFT];
   assign av_writedata  = uav_writedata;
   assign av_byteenable = uav_byteenable;

   // lanes only count for writes
   assign av_writebyteenable = {BYTEENABLE_W{uav_write}} & uav_byteenable;

   // ------------------------------
   // wait-state counter
   // ------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_cnt       <= '0;
         reset_override <= 1'b1;
      end else begin
         reset_override <= 1'b0;
         if (!uav_waitrequest || reset_override) begin
            wait_cnt <= '0;                 // accepted, restart for the next one
         end else if (transfer) begin
            wait_cnt <= wait_cnt + 1'b1;
         end else begin
            wait_cnt <= '0;
         end
      end
   end

   // slave has no waitrequest, so it comes from the counter
   assign wait_read  = (wait_cnt != READ_DONE);
   assign wait_write = (wait_cnt != WRITE_DONE);

   assign uav_waitrequest = (uav_write ? wait_write : wait_read) | reset_override;

   // one pulse per accepted read
   assign read_accept = uav_read & ~uav_waitrequest;

   // ------------------------------
   // strobe shaping
   // ------------------------------

   // read held from end of setup until acceptance
   assign av_read = uav_read & (wait_cnt >= SETUP_CYCLES);

   // write drops again for the hold cycles
   assign av_write = uav_write & (wait_cnt >= SETUP_CYCLES) & (wait_cnt <= WRITE_LAST);

   assign av_chipselect = transfer;

   assign av_begintransfer = transfer & ~end_begintransfer;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_begintransfer <= 1'b0;
      end else if (av_begintransfer && uav_waitrequest && !reset_override) begin
         end_begintransfer <= 1'b1;         // rest of this transfer
      end else if (!uav_waitrequest) begin
         end_begintransfer <= 1'b0;         // ready for the next transfer
      end
   end

   // ------------------------------
   // master protocol checks
   // ------------------------------

   // read and write are exclusive
   a_no_read_and_write : assert property (
      @(posedge clk) disable iff (reset) !(uav_read && uav_write))
      else $error("read and write asserted in the same cycle");

   // master holds the address until the transfer is accepted
   a_address_stable : assert property (
      @(posedge clk) disable iff (reset)
      transfer && uav_waitrequest |=> $stable(uav_address))
      else $error("address changed while waitrequest held the transfer");

endmodule

//--- read_return.sv
// translator read return path
module read_return
   import translator_pkg::*;
#(
   parameter int READ_LATENCY = 2
) (
   input  logic  clk,
   input  logic  reset,

   // from the request stage
   input  logic  read_accept,

   // slave read data, valid READ_LATENCY cycles after acceptance
   input  data_t av_readdata,

   // master side
   output logic  uav_readdatavalid,
   output data_t uav_readdata
);

   // ------------------------------
   // parameter check
   // ------------------------------

   // slave data never returns in the acceptance cycle
   if (READ_LATENCY < 1) begin : g_latency_check
      $error("READ_LATENCY must be at least 1");
   end

   // ------------------------------
   // latency pipe
   // ------------------------------

   // one token per accepted read, stage 0 is one cycle after acceptance
   logic [READ_LATENCY-1:0] token_pipe;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         token_pipe <= '0;
      end else begin
         token_pipe[0] <= read_accept;
         for (int i = 1; i < READ_LATENCY; i++) begin
            token_pipe[i] <= token_pipe[i-1];
         end
      end
   end

   // back-to-back reads simply sit in adjacent stages
   assign uav_readdatavalid = token_pipe[READ_LATENCY-1];

   // ------------------------------
   // read data
   // ------------------------------

   // slave drives its data in the token's last cycle, so no storage needed;
   // outside valid cycles the bus is held at zero
   assign uav_readdata = uav_readdatavalid ? av_readdata : '0;

   // ------------------------------
   // check
   // ------------------------------

   // every valid traces back to an accepted read
   a_valid_has_accept : assert property (
      @(posedge clk) disable iff (reset)
      uav_readdatavalid |-> $past(read_accept, READ_LATENCY))
      else $error("readdatavalid without a read accepted %0d cycles earlier",
                  READ_LATENCY);

endmodule

//--- slave_translator.sv
// memory-mapped slave translator
module slave_translator
   import translator_pkg::*;
#(
   // slave timing, in clock cycles
   parameter int SETUP_CYCLES      = 1,
   parameter int READ_WAIT_CYCLES  = 2,
   parameter int WRITE_WAIT_CYCLES = 1,
   parameter int HOLD_CYCLES       = 1,
   parameter int READ_LATENCY      = 2   // at least 1
) (
   input  logic      clk,
   input  logic      reset,

   // ------------------------------
   // master side
   // ------------------------------
   input  uav_addr_t uav_address,       // byte address
   input  data_t     uav_writedata,
   input  byteen_t   uav_byteenable,
   input  logic      uav_read,
   input  logic      uav_write,
   output logic      uav_waitrequest,
   output data_t     uav_readdata,
   output logic      uav_readdatavalid,

   // ------------------------------
   // slave side
   // ------------------------------
   output av_addr_t  av_address,        // word address
   output data_t     av_writedata,
   output byteen_t   av_byteenable,
   output byteen_t   av_writebyteenable,
   output logic      av_read,
   output logic      av_write,
   output logic      av_begintransfer,
   output logic      av_chipselect,
   input  data_t     av_readdata
);

   logic read_accept;   // accepted read, one cycle

   // wait states, strobes and address mapping
   request_stage #(
      .SETUP_CYCLES      (SETUP_CYCLES),
      .READ_WAIT_CYCLES  (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES (WRITE_WAIT_CYCLES),
      .HOLD_CYCLES       (HOLD_CYCLES)
   ) request_stage_i (
      .clk                (clk),
      .reset              (reset),
      .uav_address        (uav_address),
      .uav_writedata      (uav_writedata),
      .uav_byteenable     (uav_byteenable),
      .uav_read           (uav_read),
      .uav_write          (uav_write),
      .uav_waitrequest    (uav_waitrequest),
      .read_accept        (read_accept),
      .av_address         (av_address),
      .av_writedata       (av_writedata),
      .av_byteenable      (av_byteenable),
      .av_writebyteenable (av_writebyteenable),
      .av_read            (av_read),
      .av_write           (av_write),
      .av_begintransfer   (av_begintransfer),
      .av_chipselect      (av_chipselect)
   );

   // fixed-latency read data back to the master
   read_return #(
      .READ_LATENCY (READ_LATENCY)
   ) read_return_i (
      .clk               (clk),
      .reset             (reset),
      .read_accept       (read_accept),
      .av_readdata       (av_readdata),
      .uav_readdatavalid (uav_readdatavalid),
      .uav_readdata      (uav_readdata)
   );

endmodule

//--- fixed_latency_slave_model.sv
// fixed timing slave memory
module fixed_latency_slave_model
   import translator_pkg::*;
#(
   parameter int READ_WAIT_CYCLES = 2,
   parameter int READ_LATENCY     = 2
) (
   input  logic     clk,
   input  logic     reset,
   input  av_addr_t av_address,
   input  data_t    av_writedata,
   input  byteen_t  av_writebyteenable,
   input  logic     av_read,
   input  logic     av_write,
   output data_t    av_readdata
);

   localparam int MEM_AW    = 6;
   localparam int MEM_WORDS = 1 << MEM_AW;

   data_t mem [MEM_WORDS];
   data_t data_pipe [READ_LATENCY];   // read data on its way back
   int    read_cnt;                   // cycles of av_read so far
   logic  read_take;

   // read is sampled in the last read-wait cycle
   assign read_take = av_read && (read_cnt == READ_WAIT_CYCLES);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         read_cnt <= 0;
         for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= '0;
         end
         for (int i = 0; i < READ_LATENCY; i++) begin
            data_pipe[i] <= '0;
         end
      end else begin
         if (read_take || !av_read) begin
            read_cnt <= 0;
         end else begin
            read_cnt <= read_cnt + 1;
         end
         if (av_write) begin
            for (int b = 0; b < BYTEENABLE_W; b++) begin
               if (av_writebyteenable[b]) begin
                  mem[av_address[MEM_AW-1:0]][b*8 +: 8] <= av_writedata[b*8 +: 8];
               end
            end
         end
         data_pipe[0] <= read_take ? mem[av_address[MEM_AW-1:0]] : '0;
         for (int i = 1; i < READ_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
         end
      end
   end

   assign av_readdata = data_pipe[READ_LATENCY-1];

endmodule

//--- tb_checks.svh
// testbench checks and transfers

// ------------------------------
// compare tasks
// ------------------------------

task automatic report_failure(input string what);
   $display("%s", what);
   $display("Verification failed");
   $fatal(1, "stopped at the first error");
endtask

task automatic check_data(input string name, input data_t exp, input data_t act);
   if (act !== exp) begin
      report_failure($sformatf("mismatch %s expected %h actual %h", name, exp, act));
   end
endtask

task automatic check_word_addr(input string name, input av_addr_t exp, input av_addr_t act);
   if (act !== exp) begin
      report_failure($sformatf("mismatch %s expected %h actual %h", name, exp, act));
   end
endtask

task automatic check_byteen(input string name, input byteen_t exp, input byteen_t act);
   if (act !== exp) begin
      report_failure($sformatf("mismatch %s expected %b actual %b", name, exp, act));
   end
endtask

task automatic check_count(input string name, input int exp, input int act);
   if (act != exp) begin
      report_failure($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
   end
endtask

task automatic check_level(input string name, input logic exp, input logic act);
   if (act !== exp) begin
      report_failure($sformatf("mismatch %s expected %b actual %b", name, exp, act));
   end
endtask

// word slot of a byte address in the 64-word memory
function automatic int shadow_index(input uav_addr_t addr);
   return int'((addr >> WORD_SHIFT) % MEM_WORDS);
endfunction

// ------------------------------
// transfers
// ------------------------------

task automatic write_word(input string name, input uav_addr_t addr, input data_t data,
                          input byteen_t be, output int accept_cycles,
                          output int strobe_cycles, output int begin_cycles,
                          output int select_cycles);
   logic accepted;
   int   idx;
   accepted      = 1'b0;
   accept_cycles = 0;
   strobe_cycles = 0;
   begin_cycles  = 0;
   select_cycles = 0;
   @(posedge clk);
   #DRIVE_DELAY;
   uav_address    = addr;
   uav_writedata  = data;
   uav_byteenable = be;
   uav_write      = 1'b1;
   while (!accepted) begin
      @(negedge clk);
      accept_cycles++;
      check_word_addr({name, " address"}, av_addr_t'(addr >> WORD_SHIFT), av_address);
      check_data({name, " writedata"}, data, av_writedata);
      check_byteen({name, " byteenable"}, be, av_byteenable);
      check_byteen({name, " writebyteenable"}, be, av_writebyteenable);
      if (accept_cycles == 1) check_level({name, " first begintransfer"}, 1'b1, av_begintransfer);
      if (av_write) strobe_cycles++;
      if (av_begintransfer) begin_cycles++;
      if (av_chipselect) select_cycles++;
      if (!uav_waitrequest) begin
         accepted = 1'b1;
      end else if (accept_cycles >= TRANSFER_LIMIT) begin
         report_failure($sformatf("%s: write to %h was never accepted", name, addr));
      end
   end
   @(posedge clk);
   #DRIVE_DELAY;
   uav_write = 1'b0;
   idx = shadow_index(addr);
   for (int b = 0; b < BYTEENABLE_W; b++) begin
      if (be[b]) shadow_mem[idx][b*8 +: 8] = data[b*8 +: 8];
   end
endtask

task automatic read_word(input string name, input uav_addr_t addr, output data_t rdata,
                         output int accept_cycles, output int strobe_cycles,
                         output int begin_cycles, output int latency);
   logic accepted;
   logic got_data;
   accepted      = 1'b0;
   got_data      = 1'b0;
   accept_cycles = 0;
   strobe_cycles = 0;
   begin_cycles  = 0;
   latency       = 0;
   rdata         = '0;
   @(posedge clk);
   #DRIVE_DELAY;
   uav_address    = addr;
   uav_byteenable = '1;
   uav_read       = 1'b1;
   while (!accepted) begin
      @(negedge clk);
      accept_cycles++;
      check_word_addr({name, " address"}, av_addr_t'(addr >> WORD_SHIFT), av_address);
      check_byteen({name, " byteenable"}, 4'b1111, av_byteenable);
      check_byteen({name, " writebyteenable"}, 4'b0000, av_writebyteenable);
      if (accept_cycles == 1) check_level({name, " first begintransfer"}, 1'b1, av_begintransfer);
      if (av_read) strobe_cycles++;
      if (av_begintransfer) begin_cycles++;
      if (!uav_waitrequest) begin
         accepted = 1'b1;
      end else if (accept_cycles >= TRANSFER_LIMIT) begin
         report_failure($sformatf("%s: read from %h was never accepted", name, addr));
      end
   end
   @(posedge clk);
   #DRIVE_DELAY;
   uav_read = 1'b0;
   while (!got_data) begin
      @(negedge clk);
      latency++;   // cycles after the acceptance cycle
      if (uav_readdatavalid) begin
         got_data = 1'b1;
         rdata    = uav_readdata;
      end else if (latency >= TRANSFER_LIMIT) begin
         report_failure($sformatf("%s: no read data came back for %h", name, addr));
      end
   end
endtask

//--- tb_slave_translator.sv
// slave translator testbench
module tb_slave_translator
   import translator_pkg::*;
();

   localparam int SETUP_CYCLES      = 1;
   localparam int READ_WAIT_CYCLES  = 2;
   localparam int WRITE_WAIT_CYCLES = 1;
   localparam int HOLD_CYCLES       = 1;
   localparam int READ_LATENCY      = 2;
   localparam int CLK_PERIOD        = 40;
   localparam int DRIVE_DELAY       = 5;
   localparam int NUM_TESTS         = 5;
   localparam int TRANSFER_LIMIT    = 32;   // cycles before a transfer counts as stuck
   localparam int MEM_WORDS         = 64;

   logic      clk;
   logic      reset;
   uav_addr_t uav_address;
   data_t     uav_writedata;
   byteen_t   uav_byteenable;
   logic      uav_read;
   logic      uav_write;
   logic      uav_waitrequest;
   data_t     uav_readdata;
   logic      uav_readdatavalid;
   av_addr_t  av_address;
   data_t     av_writedata;
   byteen_t   av_byteenable;
   byteen_t   av_writebyteenable;
   logic      av_read;
   logic      av_write;
   logic      av_begintransfer;
   logic      av_chipselect;
   data_t     av_readdata;

   data_t shadow_mem [MEM_WORDS];   // expected memory contents
   int    seed;

   `include "tb_checks.svh"

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   slave_translator #(
      .SETUP_CYCLES      (SETUP_CYCLES),
      .READ_WAIT_CYCLES  (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES (WRITE_WAIT_CYCLES),
      .HOLD_CYCLES       (HOLD_CYCLES),
      .READ_LATENCY      (READ_LATENCY)
   ) slave_translator_i (
      .clk                (clk),
      .reset              (reset),
      .uav_address        (uav_address),
      .uav_writedata      (uav_writedata),
      .uav_byteenable     (uav_byteenable),
      .uav_read           (uav_read),
      .uav_write          (uav_write),
      .uav_waitrequest    (uav_waitrequest),
      .uav_readdata       (uav_readdata),
      .uav_readdatavalid  (uav_readdatavalid),
      .av_address         (av_address),
      .av_writedata       (av_writedata),
      .av_byteenable      (av_byteenable),
      .av_writebyteenable (av_writebyteenable),
      .av_read            (av_read),
      .av_write           (av_write),
      .av_begintransfer   (av_begintransfer),
      .av_chipselect      (av_chipselect),
      .av_readdata        (av_readdata)
   );

   fixed_latency_slave_model #(
      .READ_WAIT_CYCLES (READ_WAIT_CYCLES),
      .READ_LATENCY     (READ_LATENCY)
   ) slave_model_i (
      .clk                (clk),
      .reset              (reset),
      .av_address         (av_address),
      .av_writedata       (av_writedata),
      .av_writebyteenable (av_writebyteenable),
      .av_read            (av_read),
      .av_write           (av_write),
      .av_readdata        (av_readdata)
   );

   // ------------------------------
   // tests
   // ------------------------------

   task automatic test_reset();
      reset = 1'b1;
      repeat (2) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;
      @(negedge clk);   // first cycle out of reset
      check_level("reset waitrequest", 1'b1, uav_waitrequest);
      check_level("reset readdatavalid", 1'b0, uav_readdatavalid);
      check_level("reset av_read", 1'b0, av_read);
      check_level("reset av_write", 1'b0, av_write);
      check_level("reset begintransfer", 1'b0, av_begintransfer);
      check_level("reset chipselect", 1'b0, av_chipselect);
   endtask

   task automatic test_accept_timing();
      int    acc;
      int    strobe;
      int    bt;
      int    cs;
      int    lat;
      data_t rdata;
      write_word("accept_write", 32'h0000_0010, 32'h1111_2222, 4'hf, acc, strobe, bt, cs);
      check_count("accept_write cycles", SETUP_CYCLES + WRITE_WAIT_CYCLES + HOLD_CYCLES + 1, acc);
      check_count("accept_write begintransfer", 1, bt);
      read_word("accept_read", 32'h0000_0010, rdata, acc, strobe, bt, lat);
      check_count("accept_read cycles", SETUP_CYCLES + READ_WAIT_CYCLES + 1, acc);
      check_count("accept_read begintransfer", 1, bt);
      check_count("accept_read av_read", READ_WAIT_CYCLES + 1, strobe);
      check_data("accept_read data", shadow_mem[shadow_index(32'h0000_0010)], rdata);
   endtask

   task automatic test_write_strobes();
      int acc;
      int strobe;
      int bt;
      int cs;
      write_word("write_strobes", 32'h0000_0024, 32'hcafe_f00d, 4'hf, acc, strobe, bt, cs);
      check_count("write_strobes av_write", WRITE_WAIT_CYCLES + 1, strobe);
      check_count("write_strobes chipselect", SETUP_CYCLES + WRITE_WAIT_CYCLES + HOLD_CYCLES + 1, cs);
   endtask

   task automatic test_address_mapping();
      int        acc;
      int        strobe;
      int        bt;
      int        lat;
      data_t     rdata;
      uav_addr_t addr;
      repeat (20) begin
         addr = uav_addr_t'($random(seed));
         read_word("address_mapping", addr, rdata, acc, strobe, bt, lat);
         check_data("address_mapping data", shadow_mem[shadow_index(addr)], rdata);
      end
   endtask

   task automatic test_merge_read();
      int    acc;
      int    strobe;
      int    bt;
      int    cs;
      int    lat;
      data_t rdata;
      write_word("merge_full", 32'h0000_00c8, 32'h1234_5678, 4'b1111, acc, strobe, bt, cs);
      write_word("merge_partial", 32'h0000_00c8, 32'haabb_ccdd, 4'b0101, acc, strobe, bt, cs);
      read_word("merge_read", 32'h0000_00c8, rdata, acc, strobe, bt, lat);
      check_count("merge_read latency", READ_LATENCY, lat);
      check_data("merge_read shadow", shadow_mem[shadow_index(32'h0000_00c8)], rdata);
      check_data("merge_read word", 32'h12bb_56dd, rdata);   // lanes 0 and 2 replaced
   endtask

   // ------------------------------
   // run
   // ------------------------------

   initial begin
      #(NUM_TESTS * 200 * CLK_PERIOD);
      $display("timeout: the tests did not finish within %0d cycles", NUM_TESTS * 200);
      $display("Verification failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      seed           = 55485;
      reset          = 1'b1;
      uav_address    = '0;
      uav_writedata  = '0;
      uav_byteenable = '0;
      uav_read       = 1'b0;
      uav_write      = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         shadow_mem[i] = '0;   // model memory clears on reset
      end
      test_reset();
      test_accept_timing();
      test_write_strobes();
      test_address_mapping();
      test_merge_read();
      $display("Verification passed");
      $finish;
   end

endmodule

//--- src.f
+incdir+.
translator_pkg.sv
request_stage.sv
read_return.sv
slave_translator.sv
fixed_latency_slave_model.sv
tb_slave_translator.sv
